// ==== list.f ====
rtl/cache_pkg.sv
rtl/cache_line_store.sv
rtl/cache_direct.sv
rtl/line_memory.sv
rtl/cache_subsystem.sv
tb/cache_props.sv
tb/cache_tb.sv

// ==== rtl/cache_direct.sv ====
module cache_direct (
	input logic clk,
	input logic reset,
	input logic master_enable,
	input cache_pkg::cpu_req_t req,
	output cache_pkg::line_t data_out,
	output logic hit,
	// Line store
	output cache_pkg::addr_t lookup_addr,
	output logic wr_en,
	output cache_pkg::byte_en_t byte_enable,
	output cache_pkg::line_t wr_data,
	output logic fill_en,
	output cache_pkg::addr_t fill_addr,
	output cache_pkg::line_t fill_data,
	output logic invalidate,
	input logic lookup_hit,
	input cache_pkg::line_t line_data,
	input cache_pkg::tag_t victim_tag,
	input logic victim_dirty,
	// Backing memory
	output logic mem_write_req,
	output cache_pkg::mem_req_t mem_write,
	input logic mem_write_ack,
	output logic mem_read_req,
	output cache_pkg::addr_t mem_read_addr,
	input cache_pkg::line_t mem_read_data,
	input logic mem_read_ack
);
	import cache_pkg::*;

	cache_state_t state;
	index_t index;
	logic accept;
	logic miss;

	assign index = addr_index(req.addr);

	// The request is still held during its own hit cycle, so skip it there
	assign accept = master_enable && !hit && (state == lookup);
	assign miss = accept && !lookup_hit;

	////////////////////////////////////////////////////////////////////////////
	// Store strobes
	////////////////////////////////////////////////////////////////////////////
	assign lookup_addr = req.addr;
	assign wr_en = accept && lookup_hit && !req.read_write;
	assign byte_enable = req.byte_enable;
	assign wr_data = req.data;

	// Victim fields are captured below in the same cycle
	assign invalidate = miss;

	assign fill_en = (state == fill) && mem_read_ack;
	assign fill_addr = mem_read_addr;
	assign fill_data = mem_read_data;

	////////////////////////////////////////////////////////////////////////////
	// Miss sequencing
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= lookup;
			hit <= 1'b0;
			mem_write_req <= 1'b0;
			mem_read_req <= 1'b0;
		end else begin
			hit <= accept && lookup_hit;
			case (state)
				lookup: begin
					if (miss) begin
						if (victim_dirty) begin
							mem_write_req <= 1'b1;
							state <= evict;
						end else begin
							mem_read_req <= 1'b1;
							state <= fill;
						end
					end
				end
				evict: begin
					// Refill starts only once the write-back is taken
					if (mem_write_ack) begin
						mem_write_req <= 1'b0;
						mem_read_req <= 1'b1;
						state <= fill;
					end
				end
				fill: begin
					// Back to lookup, which then hits on the new line
					if (mem_read_ack) begin
						mem_read_req <= 1'b0;
						state <= lookup;
					end
				end
				default: begin
					state <= lookup;
				end
			endcase
		end
	end

	// Response line, stored or merged
	always_ff @(posedge clk) begin
		if (accept && lookup_hit) begin
			data_out <= line_data;
		end
	end

	// Eviction and fill addresses, fixed for the whole miss
	always_ff @(posedge clk) begin
		if (miss) begin
			mem_write.addr <= line_base(victim_tag, index);
			mem_write.data <= line_data;
			mem_read_addr <= line_base(addr_tag(req.addr), index);
		end
	end

endmodule

// ==== rtl/cache_line_store.sv ====
module cache_line_store (
	input logic clk,
	input logic reset,
	input cache_pkg::addr_t lookup_addr,
	input logic wr_en,
	input cache_pkg::byte_en_t byte_enable,
	input cache_pkg::line_t wr_data,
	input logic fill_en,
	input cache_pkg::addr_t fill_addr,
	input cache_pkg::line_t fill_data,
	input logic invalidate,
	output logic lookup_hit,
	output cache_pkg::line_t line_data,
	output cache_pkg::tag_t victim_tag,
	output logic victim_dirty
);
	import cache_pkg::*;

	tag_t tags [CACHE_DEPTH];
	line_t lines [CACHE_DEPTH];
	logic [CACHE_DEPTH-1:0] valid;
	logic [CACHE_DEPTH-1:0] dirty;

	index_t index;
	tag_t tag;
	index_t fill_index;
	byte_en_t lane_en;
	line_t bit_mask;
	line_t merged;

	assign index = addr_index(lookup_addr);
	assign tag = addr_tag(lookup_addr);
	assign fill_index = addr_index(fill_addr);

	// Lanes only take effect while a write is strobed,
	// so a read or a victim sees the stored line unchanged
	assign lane_en = wr_en ? byte_enable : '0;

	always_comb begin
		for (int i = 0; i < LINE_BYTES; i++) begin
			bit_mask[8*i +: 8] = {8{lane_en[i]}};
		end
	end

	assign merged = (lines[index] & ~bit_mask) | (wr_data & bit_mask);

	// Lookup results
	assign lookup_hit = valid[index] && (tags[index] == tag);
	assign line_data = merged;
	assign victim_tag = tags[index];
	assign victim_dirty = valid[index] && dirty[index];

	////////////////////////////////////////////////////////////////////////////
	// Status bits
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (fill_en) begin
			valid[fill_index] <= 1'b1;
			dirty[fill_index] <= 1'b0;
		end else if (invalidate) begin
			valid[index] <= 1'b0;
			dirty[index] <= 1'b0;
		end else if (wr_en) begin
			dirty[index] <= 1'b1;
		end
	end

	// Tag and data arrays
	always_ff @(posedge clk) begin
		if (fill_en) begin
			lines[fill_index] <= fill_data;
			tags[fill_index] <= addr_tag(fill_addr);
		end else if (wr_en) begin
			lines[index] <= merged;
		end
	end

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Cache geometry
	////////////////////////////////////////////////////////////////////////////
	localparam int LINE_WIDTH = 128;
	localparam int LINE_BYTES = LINE_WIDTH / 8;
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);
	localparam int CACHE_DEPTH = 4;
	localparam int INDEX_BITS = $clog2(CACHE_DEPTH);
	localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

	// Backing memory
	localparam int MEM_LINES = 64;
	localparam int MEM_LATENCY = 3;

	typedef logic [31:0] addr_t;
	typedef logic [LINE_WIDTH-1:0] line_t;
	typedef logic [LINE_BYTES-1:0] byte_en_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;

	typedef struct packed {
		addr_t addr;
		logic read_write;
		byte_en_t byte_enable;
		line_t data;
	} cpu_req_t;

	typedef struct packed {
		addr_t addr;
		line_t data;
	} mem_req_t;

	typedef enum logic [1:0] {lookup, evict, fill} cache_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Address fields: tag | index | offset
	////////////////////////////////////////////////////////////////////////////
	function automatic index_t addr_index(addr_t addr);
		return addr[OFFSET_BITS +: INDEX_BITS];
	endfunction

	function automatic tag_t addr_tag(addr_t addr);
		return addr[31 -: TAG_BITS];
	endfunction

	// Line-aligned byte address
	function automatic addr_t line_base(tag_t tag, index_t index);
		return {tag, index, {OFFSET_BITS{1'b0}}};
	endfunction

endpackage

// ==== rtl/cache_subsystem.sv ====
module cache_subsystem (
	input logic clk,
	input logic reset,
	input logic master_enable,
	input cache_pkg::cpu_req_t req,
	output cache_pkg::line_t data_out,
	output logic hit
);
	import cache_pkg::*;

	// Controller to line store
	addr_t lookup_addr;
	logic wr_en;
	byte_en_t byte_enable;
	line_t wr_data;
	logic fill_en;
	addr_t fill_addr;
	line_t fill_data;
	logic invalidate;
	logic lookup_hit;
	line_t line_data;
	tag_t victim_tag;
	logic victim_dirty;

	// Controller to backing memory
	logic mem_write_req;
	mem_req_t mem_write;
	logic mem_write_ack;
	logic mem_read_req;
	addr_t mem_read_addr;
	line_t mem_read_data;
	logic mem_read_ack;

	cache_direct u_ctrl (
		.clk(clk),
		.reset(reset),
		.master_enable(master_enable),
		.req(req),
		.data_out(data_out),
		.hit(hit),
		.lookup_addr(lookup_addr),
		.wr_en(wr_en),
		.byte_enable(byte_enable),
		.wr_data(wr_data),
		.fill_en(fill_en),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.invalidate(invalidate),
		.lookup_hit(lookup_hit),
		.line_data(line_data),
		.victim_tag(victim_tag),
		.victim_dirty(victim_dirty),
		.mem_write_req(mem_write_req),
		.mem_write(mem_write),
		.mem_write_ack(mem_write_ack),
		.mem_read_req(mem_read_req),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data),
		.mem_read_ack(mem_read_ack)
	);

	cache_line_store u_store (
		.clk(clk),
		.reset(reset),
		.lookup_addr(lookup_addr),
		.wr_en(wr_en),
		.byte_enable(byte_enable),
		.wr_data(wr_data),
		.fill_en(fill_en),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.invalidate(invalidate),
		.lookup_hit(lookup_hit),
		.line_data(line_data),
		.victim_tag(victim_tag),
		.victim_dirty(victim_dirty)
	);

	line_memory u_mem (
		.clk(clk),
		.reset(reset),
		.write_req(mem_write_req),
		.write(mem_write),
		.write_ack(mem_write_ack),
		.read_req(mem_read_req),
		.read_addr(mem_read_addr),
		.read_data(mem_read_data),
		.read_ack(mem_read_ack)
	);

endmodule

// ==== rtl/line_memory.sv ====
module line_memory (
	input logic clk,
	input logic reset,
	input logic write_req,
	input cache_pkg::mem_req_t write,
	output logic write_ack,
	input logic read_req,
	input cache_pkg::addr_t read_addr,
	output cache_pkg::line_t read_data,
	output logic read_ack
);
	import cache_pkg::*;

	typedef logic [$clog2(MEM_LATENCY+1)-1:0] count_t;
	typedef logic [$clog2(MEM_LINES)-1:0] mem_index_t;

	line_t mem [MEM_LINES];
	mem_index_t write_line;
	mem_index_t read_line;

	// Channel 0 carries writes, channel 1 reads
	logic [1:0] req;
	logic [1:0] busy;
	logic [1:0] done;
	logic [1:0] ack;
	count_t count [2];

	assign req = {read_req, write_req};
	assign write_ack = ack[0];
	assign read_ack = ack[1];

	// Line address modulo the memory size
	assign write_line = write.addr[OFFSET_BITS +: $bits(mem_index_t)];
	assign read_line = read_addr[OFFSET_BITS +: $bits(mem_index_t)];

	always_comb begin
		for (int ch = 0; ch < 2; ch++) begin
			done[ch] = busy[ch] && (count[ch] == count_t'(1));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Acknowledge countdown
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
			ack <= '0;
			for (int ch = 0; ch < 2; ch++) begin
				count[ch] <= '0;
			end
		end else begin
			for (int ch = 0; ch < 2; ch++) begin
				ack[ch] <= done[ch];
				if (done[ch]) begin
					busy[ch] <= 1'b0;
				end else if (busy[ch]) begin
					count[ch] <= count[ch] - 1'b1;
				end else if (req[ch] && !ack[ch]) begin
					// Request still high during its ack is the old one
					busy[ch] <= 1'b1;
					count[ch] <= count_t'(MEM_LATENCY - 1);
				end
			end
		end
	end

	// Line storage, written as the write is acknowledged
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < MEM_LINES; i++) begin
				mem[i] <= '0;
			end
		end else if (done[0]) begin
			mem[write_line] <= write.data;
		end
	end

	always_ff @(posedge clk) begin
		if (done[1]) begin
			read_data <= mem[read_line];
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module cache_tb -f list.f -o cache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

// ==== tb/cache_props.sv ====
module cache_props (
	input logic clk,
	input logic reset,
	input logic hit,
	input logic mem_write_req,
	input logic mem_write_ack,
	input logic mem_read_req,
	input logic mem_read_ack
);

	////////////////////////////////////////////////////////////////////////////
	// Reset
	////////////////////////////////////////////////////////////////////////////
	reset_clears: assert property (@(posedge clk)
		reset |=> !hit && !mem_write_req && !mem_read_req)
		else $error("hit or a memory request is high right after reset");

	////////////////////////////////////////////////////////////////////////////
	// Memory handshakes
	////////////////////////////////////////////////////////////////////////////
	write_held: assert property (@(posedge clk) disable iff (reset)
		mem_write_req && !mem_write_ack |=> mem_write_req)
		else $error("write request dropped before its acknowledge");

	read_held: assert property (@(posedge clk) disable iff (reset)
		mem_read_req && !mem_read_ack |=> mem_read_req)
		else $error("read request dropped before its acknowledge");

	// Eviction has to finish before the refill starts
	read_after_write: assert property (@(posedge clk) disable iff (reset)
		mem_write_req |-> !mem_read_req)
		else $error("read request raised while a write request is pending");

	// Processor response
	hit_pulse: assert property (@(posedge clk) disable iff (reset)
		hit |=> !hit)
		else $error("hit stayed high for more than one cycle");

endmodule

// ==== tb/cache_stimulus.txt ====
// Columns: op (0 read, 1 write, f end), byte address, lane enables, write data, expected data_out
// Data and expected values are whole 128-bit lines, lane 0 in the rightmost byte
// Untouched line misses, then hits
0 00000000 0000 00000000000000000000000000000000 00000000000000000000000000000000
0 00000000 0000 00000000000000000000000000000000 00000000000000000000000000000000
// Byte-masked writes on a resident line
1 00000000 00ff 11111111222222223333333344444444 00000000000000003333333344444444
1 00000000 8001 aabbccddeeff00112233445566778899 aa000000000000003333333344444499
// Dirty eviction by same index, then read back
0 00000040 0000 00000000000000000000000000000000 00000000000000000000000000000000
0 00000000 0000 00000000000000000000000000000000 aa000000000000003333333344444499
// Clean conflict miss and refill of written-back data
0 00000080 0000 00000000000000000000000000000000 00000000000000000000000000000000
0 00000000 0000 00000000000000000000000000000000 aa000000000000003333333344444499
// Mixed traffic over all four indexes
1 00000010 ffff 01010101020202020303030304040404 01010101020202020303030304040404
1 00000020 0ff0 123456789abcdef00fedcba987654321 000000009abcdef00fedcba900000000
1 00000030 f000 deadbeef000000000000000000000000 deadbeef000000000000000000000000
0 00000010 0000 00000000000000000000000000000000 01010101020202020303030304040404
1 00000050 000f ffffffffffffffffffffffffcafef00d 000000000000000000000000cafef00d
0 00000020 0000 00000000000000000000000000000000 000000009abcdef00fedcba900000000
1 000000a0 3c3c 112233445566778899aabbccddeeff00 00003344556600000000bbccddee0000
0 00000010 0000 00000000000000000000000000000000 01010101020202020303030304040404
0 00000070 0000 00000000000000000000000000000000 00000000000000000000000000000000
1 00000020 ff00 a5a5a5a55a5a5a5a0000000000000000 a5a5a5a55a5a5a5a0fedcba900000000
0 000000a0 0000 00000000000000000000000000000000 00003344556600000000bbccddee0000
0 00000030 0000 00000000000000000000000000000000 deadbeef000000000000000000000000
1 000003f0 ffff 0f0f0f0ff0f0f0f00f0f0f0ff0f0f0f0 0f0f0f0ff0f0f0f00f0f0f0ff0f0f0f0
1 00000110 00f0 00000000000000007654321000000000 00000000000000007654321000000000
0 00000050 0000 00000000000000000000000000000000 000000000000000000000000cafef00d
0 00000220 0000 00000000000000000000000000000000 00000000000000000000000000000000
0 000003f0 0000 00000000000000000000000000000000 0f0f0f0ff0f0f0f00f0f0f0ff0f0f0f0
0 00000020 0000 00000000000000000000000000000000 a5a5a5a55a5a5a5a0fedcba900000000
0 00000110 0000 00000000000000000000000000000000 00000000000000007654321000000000
1 00000110 0001 000000000000000000000000000000ab 000000000000000076543210000000ab
0 00000000 0000 00000000000000000000000000000000 aa000000000000003333333344444499
0 00000030 0000 00000000000000000000000000000000 deadbeef000000000000000000000000
0 000003f0 0000 00000000000000000000000000000000 0f0f0f0ff0f0f0f00f0f0f0ff0f0f0f0
// End of records
f 00000000 0000 00000000000000000000000000000000 00000000000000000000000000000000

// ==== tb/cache_tb.sv ====
module cache_tb;
	import cache_pkg::*;

	localparam int MAX_RECORDS = 48;
	localparam int RECORD_WORDS = 5;
	localparam int HIT_TIMEOUT = 100;

	logic clk;
	logic reset;
	logic master_enable;
	cpu_req_t req;
	line_t data_out;
	logic hit;

	// Op, address, lane enables, write data, expected data_out
	line_t stimulus [RECORD_WORDS*MAX_RECORDS];

	// Which tag each cache line should hold
	tag_t model_tag [CACHE_DEPTH];
	logic [CACHE_DEPTH-1:0] model_valid;

	cache_subsystem dut0 (
		.clk(clk),
		.reset(reset),
		.master_enable(master_enable),
		.req(req),
		.data_out(data_out),
		.hit(hit)
	);

	bind cache_direct cache_props props0 (
		.clk(clk),
		.reset(reset),
		.hit(hit),
		.mem_write_req(mem_write_req),
		.mem_write_ack(mem_write_ack),
		.mem_read_req(mem_read_req),
		.mem_read_ack(mem_read_ack)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input line_t actual, input line_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// Counts rising edges from the request to the hit
	task automatic wait_for_hit(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (!hit) begin
			cycles++;
			if (cycles > HIT_TIMEOUT) begin
				$display("No hit within %0d cycles for address 0x%h", HIT_TIMEOUT, req.addr);
				$display("TEST FAIL");
				$fatal(1, "hit timeout");
			end
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Request loop
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int rec;
		int base;
		int cycles;
		addr_t addr;
		index_t idx;
		tag_t tag;
		logic expect_hit;
		cpu_req_t next_req;

		reset = 1'b1;
		master_enable = 1'b0;
		req = '0;
		model_valid = '0;
		for (int i = 0; i < RECORD_WORDS*MAX_RECORDS; i++) begin
			stimulus[i] = '1;
		end
		$readmemh("tb/cache_stimulus.txt", stimulus);

		repeat (10) begin
			@(posedge clk);
		end
		reset <= 1'b0;
		@(negedge clk);
		check_value("hit", line_t'(hit), '0);

		rec = 0;
		base = 0;
		while (rec < MAX_RECORDS && stimulus[base][3:0] != 4'hf) begin
			addr = stimulus[base+1][31:0];
			idx = addr[OFFSET_BITS +: INDEX_BITS];
			tag = addr[31 -: TAG_BITS];
			expect_hit = model_valid[idx] && (model_tag[idx] == tag);

			next_req.addr = addr;
			next_req.read_write = (stimulus[base][3:0] == 4'h0);
			next_req.byte_enable = stimulus[base+2][LINE_BYTES-1:0];
			next_req.data = stimulus[base+3];

			@(posedge clk);
			master_enable <= 1'b1;
			req <= next_req;
			wait_for_hit(cycles);

			check_value("data_out", data_out, stimulus[base+4]);
			if (expect_hit) begin
				check_value("hit latency", line_t'(cycles), line_t'(1));
			end else begin
				// A miss has to go through the memory first
				check_value("hit latency above one cycle", line_t'(cycles > 1), line_t'(1));
			end

			model_valid[idx] = 1'b1;
			model_tag[idx] = tag;
			rec++;
			base = base + RECORD_WORDS;
		end

		@(posedge clk);
		master_enable <= 1'b0;
		@(posedge clk);

		if (rec == 0) begin
			$display("No records were read from the stimulus file");
			$display("TEST FAIL");
			$fatal(1, "empty stimulus");
		end else begin
			$display("%0d requests checked", rec);
			$display("TEST PASS");
			$finish;
		end
	end

endmodule
